// File: verilog/rooth_pkg.sv
package rooth_pkg;

    // --------------------------------------------------
    // Widths and sizes
    // --------------------------------------------------
    localparam int CPU_WIDTH      = 32;
    localparam int FUNCT3_WIDTH   = 3;
    localparam int OPCODE_WIDTH   = 7;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int CSR_IDX_WIDTH  = 2;
    localparam int MEM_DEPTH      = 64;
    localparam int MEM_ADDR_WIDTH = 6;
    localparam int WIDTH_RESCTRL  = 2;

    // Where the result of an instruction ends up
    localparam logic [WIDTH_RESCTRL-1:0] RESCTRL_NONE = 2'd0;
    localparam logic [WIDTH_RESCTRL-1:0] RESCTRL_REG  = 2'd1;
    localparam logic [WIDTH_RESCTRL-1:0] RESCTRL_MEM  = 2'd2;
    localparam logic [WIDTH_RESCTRL-1:0] RESCTRL_CSR  = 2'd3;

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    localparam logic [OPCODE_WIDTH-1:0] INST_TYPE_R   = 7'b0110011;
    localparam logic [OPCODE_WIDTH-1:0] INST_TYPE_I   = 7'b0010011;
    localparam logic [OPCODE_WIDTH-1:0] INST_TYPE_IL  = 7'b0000011;
    localparam logic [OPCODE_WIDTH-1:0] INST_TYPE_S   = 7'b0100011;
    localparam logic [OPCODE_WIDTH-1:0] INST_TYPE_CSR = 7'b1110011;

    // --------------------------------------------------
    // Funct3 codes
    // --------------------------------------------------
    localparam logic [FUNCT3_WIDTH-1:0] INST_ADD    = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] INST_XOR    = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] INST_OR     = 3'b110;
    localparam logic [FUNCT3_WIDTH-1:0] INST_AND    = 3'b111;

    localparam logic [FUNCT3_WIDTH-1:0] INST_LB     = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] INST_LH     = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] INST_LW     = 3'b010;
    localparam logic [FUNCT3_WIDTH-1:0] INST_LBU    = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] INST_LHU    = 3'b101;

    localparam logic [FUNCT3_WIDTH-1:0] INST_SB     = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] INST_SH     = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] INST_SW     = 3'b010;

    localparam logic [FUNCT3_WIDTH-1:0] INST_CSRRW  = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] INST_CSRRS  = 3'b010;
    localparam logic [FUNCT3_WIDTH-1:0] INST_CSRRC  = 3'b011;
    localparam logic [FUNCT3_WIDTH-1:0] INST_CSRRWI = 3'b101;

endpackage

// File: verilog/exec_unit.sv
module exec_unit import rooth_pkg::*; (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      valid_i,
    input  logic [OPCODE_WIDTH-1:0]   opcode_i,
    input  logic [FUNCT3_WIDTH-1:0]   funct3_i,
    input  logic [REG_ADDR_WIDTH-1:0] rd_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_i,
    input  logic [CPU_WIDTH-1:0]      imm_i,
    input  logic [CSR_IDX_WIDTH-1:0]  csr_idx_i,
    input  logic [CPU_WIDTH-1:0]      rs1_data_i,
    input  logic [CPU_WIDTH-1:0]      rs2_data_i,
    input  logic [CPU_WIDTH-1:0]      csr_rd_data_i,
    output logic [REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [REG_ADDR_WIDTH-1:0] rs2_addr_o,
    output logic [REG_ADDR_WIDTH-1:0] rd_o,
    output logic [CSR_IDX_WIDTH-1:0]  csr_idx_o,
    output logic [OPCODE_WIDTH-1:0]   opcode_o,
    output logic [FUNCT3_WIDTH-1:0]   funct3_o,
    output logic [CPU_WIDTH-1:0]      imm_o,
    output logic [CPU_WIDTH-1:0]      alu_res_o,
    output logic [WIDTH_RESCTRL-1:0]  res_op_o,
    output logic                      reg_we_o,
    output logic                      csr_we_o
);

    logic                 valid_q;
    logic [CPU_WIDTH-1:0] op_b;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // Instruction fields qualified by valid_q
    always_ff @(posedge clk_i) begin
        opcode_o   <= opcode_i;
        funct3_o   <= funct3_i;
        rd_o       <= rd_i;
        rs1_addr_o <= rs1_i;
        rs2_addr_o <= rs2_i;
        imm_o      <= imm_i;
        csr_idx_o  <= csr_idx_i;
    end

    assign op_b = (opcode_o == INST_TYPE_R) ? rs2_data_i : imm_o;

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb begin
        alu_res_o = rs1_data_i + op_b;
        if (opcode_o == INST_TYPE_R || opcode_o == INST_TYPE_I) begin
            case (funct3_o)
                INST_XOR: alu_res_o = rs1_data_i ^ op_b;
                INST_OR:  alu_res_o = rs1_data_i | op_b;
                INST_AND: alu_res_o = rs1_data_i & op_b;
                default:  alu_res_o = rs1_data_i + op_b;
            endcase
        end else if (opcode_o == INST_TYPE_CSR) begin
            case (funct3_o)
                INST_CSRRS: alu_res_o = csr_rd_data_i | rs1_data_i;
                INST_CSRRC: alu_res_o = csr_rd_data_i & ~rs1_data_i;
                default:    alu_res_o = rs1_data_i;
            endcase
        end
    end

    // Bubbles fall to the NONE route
    always_comb begin
        res_op_o = RESCTRL_NONE;
        if (valid_q) begin
            case (opcode_o)
                INST_TYPE_R, INST_TYPE_I, INST_TYPE_IL: res_op_o = RESCTRL_REG;
                INST_TYPE_S:   res_op_o = RESCTRL_MEM;
                INST_TYPE_CSR: res_op_o = RESCTRL_CSR;
                default:       res_op_o = RESCTRL_NONE;
            endcase
        end
    end

    assign reg_we_o = (res_op_o == RESCTRL_REG || res_op_o == RESCTRL_CSR) && (rd_o != '0);
    assign csr_we_o = (res_op_o == RESCTRL_CSR);

    // Only supported opcodes arrive as valid instructions
    a_known_opcode: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) valid_q |-> (res_op_o != RESCTRL_NONE)
    );

endmodule

// File: verilog/reg_file.sv
module reg_file import rooth_pkg::*; (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_addr_i,
    input  logic [REG_ADDR_WIDTH-1:0] rd_i,
    input  logic                      we_i,
    input  logic [CPU_WIDTH-1:0]      wr_data_i,
    output logic [CPU_WIDTH-1:0]      rs1_data_o,
    output logic [CPU_WIDTH-1:0]      rs2_data_o
);

    logic [CPU_WIDTH-1:0] regs [2**REG_ADDR_WIDTH];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wr_data_i;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: verilog/csr_file.sv
module csr_file import rooth_pkg::*; (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic [CSR_IDX_WIDTH-1:0] idx_i,
    input  logic                     we_i,
    input  logic [CPU_WIDTH-1:0]     wr_data_i,
    output logic [CPU_WIDTH-1:0]     rd_data_o
);

    // Scratch registers only
    logic [CPU_WIDTH-1:0] csrs [2**CSR_IDX_WIDTH];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**CSR_IDX_WIDTH; i++) begin
                csrs[i] <= '0;
            end
        end else if (we_i) begin
            csrs[idx_i] <= wr_data_i;
        end
    end

    // Old value, seen while the new one is being formed
    assign rd_data_o = csrs[idx_i];

endmodule

// File: verilog/res_route.sv
module res_route import rooth_pkg::*; (
    input  logic [CPU_WIDTH-1:0]     rs1_data_i,
    input  logic [CPU_WIDTH-1:0]     rs2_data_i,
    input  logic [CPU_WIDTH-1:0]     csr_rd_data_i,
    input  logic [CPU_WIDTH-1:0]     imm_i,
    input  logic [FUNCT3_WIDTH-1:0]  funct3_i,
    input  logic [OPCODE_WIDTH-1:0]  opcode_i,
    input  logic [WIDTH_RESCTRL-1:0] alu_res_op_i,
    input  logic [CPU_WIDTH-1:0]     alu_res_i,
    input  logic [CPU_WIDTH-1:0]     data_mem_data_i,
    output logic [CPU_WIDTH-1:0]     data_mem_addr_o,
    output logic                     data_mem_wr_en_o,
    output logic                     data_mem_req_o,
    output logic [CPU_WIDTH-1:0]     data_mem_data_o,
    output logic [CPU_WIDTH-1:0]     reg_wr_data_o,
    output logic [CPU_WIDTH-1:0]     csr_wr_data_o
);

    logic [1:0]           lane;
    logic [CPU_WIDTH-1:0] w;

    assign lane = alu_res_i[1:0];
    assign w    = data_mem_data_i;
    assign data_mem_addr_o = alu_res_i;

    always_comb begin
        data_mem_wr_en_o = 1'b0;
        data_mem_req_o   = 1'b0;
        data_mem_data_o  = '0;
        reg_wr_data_o    = '0;
        csr_wr_data_o    = '0;
        case (alu_res_op_i)
            // ------------------------------------------
            // Store, merge into the fetched word
            // ------------------------------------------
            RESCTRL_MEM: begin
                data_mem_req_o   = 1'b1;
                data_mem_wr_en_o = 1'b1;
                case (funct3_i)
                    INST_SB: begin
                        case (lane)
                            2'b00:   data_mem_data_o = {w[31:8], rs2_data_i[7:0]};
                            2'b01:   data_mem_data_o = {w[31:16], rs2_data_i[7:0], w[7:0]};
                            2'b10:   data_mem_data_o = {w[31:24], rs2_data_i[7:0], w[15:0]};
                            default: data_mem_data_o = {rs2_data_i[7:0], w[23:0]};
                        endcase
                    end
                    INST_SH: begin
                        if (lane[1]) begin
                            data_mem_data_o = {rs2_data_i[15:0], w[15:0]};
                        end else begin
                            data_mem_data_o = {w[31:16], rs2_data_i[15:0]};
                        end
                    end
                    default: data_mem_data_o = rs2_data_i;
                endcase
            end
            // CSR swap, old value to rd
            RESCTRL_CSR: begin
                reg_wr_data_o = csr_rd_data_i;
                case (funct3_i)
                    INST_CSRRW:  csr_wr_data_o = rs1_data_i;
                    INST_CSRRWI: csr_wr_data_o = imm_i;
                    default:     csr_wr_data_o = alu_res_i;
                endcase
            end
            // ------------------------------------------
            // Register writeback, loads extend the lane
            // ------------------------------------------
            RESCTRL_REG: begin
                if (opcode_i == INST_TYPE_IL) begin
                    data_mem_req_o = 1'b1;
                    case (funct3_i)
                        INST_LB, INST_LBU: begin
                            case (lane)
                                2'b00:   reg_wr_data_o = {24'h0, w[7:0]};
                                2'b01:   reg_wr_data_o = {24'h0, w[15:8]};
                                2'b10:   reg_wr_data_o = {24'h0, w[23:16]};
                                default: reg_wr_data_o = {24'h0, w[31:24]};
                            endcase
                            if (funct3_i == INST_LB) begin
                                reg_wr_data_o[31:8] = {24{reg_wr_data_o[7]}};
                            end
                        end
                        INST_LH, INST_LHU: begin
                            reg_wr_data_o = lane[1] ? {16'h0, w[31:16]} : {16'h0, w[15:0]};
                            if (funct3_i == INST_LH) begin
                                reg_wr_data_o[31:16] = {16{reg_wr_data_o[15]}};
                            end
                        end
                        default: reg_wr_data_o = w;
                    endcase
                end else begin
                    reg_wr_data_o = alu_res_i;
                end
            end
            default: begin
                // Bubble, nothing leaves the router
            end
        endcase
    end

    // --------------------------------------------------
    // Alignment, misaligned access is not handled
    // --------------------------------------------------
    always_comb begin
        if (data_mem_req_o) begin
            if (funct3_i[1:0] == 2'b01) begin
                a_half_align: assert final (alu_res_i[0] == 1'b0);
            end
            if (funct3_i == INST_LW) begin
                a_word_align: assert final (alu_res_i[1:0] == 2'b00);
            end
        end
    end

endmodule

// File: verilog/data_ram.sv
module data_ram import rooth_pkg::*; (
    input  logic                 clk_i,
    input  logic [CPU_WIDTH-1:0] addr_i,
    input  logic                 req_i,
    input  logic                 wr_en_i,
    input  logic [CPU_WIDTH-1:0] wr_data_i,
    output logic [CPU_WIDTH-1:0] rd_data_o
);

    logic [CPU_WIDTH-1:0]      mem [MEM_DEPTH];
    logic [MEM_ADDR_WIDTH-1:0] word_idx;

    // Byte address to word index
    assign word_idx  = addr_i[MEM_ADDR_WIDTH+1:2];
    assign rd_data_o = mem[word_idx];

    always_ff @(posedge clk_i) begin
        if (req_i && wr_en_i) begin
            mem[word_idx] <= wr_data_i;
        end
    end

    // Accesses stay inside the RAM window
    a_addr_range: assert property (
        @(posedge clk_i) req_i |-> (addr_i[CPU_WIDTH-1:MEM_ADDR_WIDTH+2] == '0)
    );

endmodule

// File: verilog/mem_wb_top.sv
module mem_wb_top import rooth_pkg::*; (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      valid_i,
    input  logic [OPCODE_WIDTH-1:0]   opcode_i,
    input  logic [FUNCT3_WIDTH-1:0]   funct3_i,
    input  logic [REG_ADDR_WIDTH-1:0] rd_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_i,
    input  logic [CPU_WIDTH-1:0]      imm_i,
    input  logic [CSR_IDX_WIDTH-1:0]  csr_idx_i,
    output logic                      wb_we_o,
    output logic [REG_ADDR_WIDTH-1:0] wb_rd_o,
    output logic [CPU_WIDTH-1:0]      wb_data_o,
    output logic                      mem_we_o,
    output logic [CPU_WIDTH-1:0]      mem_addr_o,
    output logic [CPU_WIDTH-1:0]      mem_wdata_o,
    output logic                      csr_we_o
);

    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [CSR_IDX_WIDTH-1:0]  csr_idx;
    logic [OPCODE_WIDTH-1:0]   opcode;
    logic [FUNCT3_WIDTH-1:0]   funct3;
    logic [CPU_WIDTH-1:0]      rs1_data;
    logic [CPU_WIDTH-1:0]      rs2_data;
    logic [CPU_WIDTH-1:0]      csr_rd_data;
    logic [CPU_WIDTH-1:0]      imm;
    logic [CPU_WIDTH-1:0]      alu_res;
    logic [WIDTH_RESCTRL-1:0]  res_op;
    logic [CPU_WIDTH-1:0]      csr_wr_data;
    logic [CPU_WIDTH-1:0]      data_mem_rdata;
    logic                      data_mem_req;
    logic                      data_mem_wr_en;

    exec_unit exec_unit_inst (
        .clk_i, .arst_n_i, .valid_i, .opcode_i, .funct3_i,
        .rd_i, .rs1_i, .rs2_i, .imm_i, .csr_idx_i,
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .csr_rd_data_i(csr_rd_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_o(wb_rd_o),
        .csr_idx_o(csr_idx), .opcode_o(opcode), .funct3_o(funct3), .imm_o(imm),
        .alu_res_o(alu_res), .res_op_o(res_op), .reg_we_o(wb_we_o), .csr_we_o(csr_we_o)
    );

    reg_file reg_file_inst (
        .clk_i, .arst_n_i,
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .rd_i(wb_rd_o),
        .we_i(wb_we_o), .wr_data_i(wb_data_o),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    csr_file csr_file_inst (
        .clk_i, .arst_n_i, .idx_i(csr_idx), .we_i(csr_we_o),
        .wr_data_i(csr_wr_data), .rd_data_o(csr_rd_data)
    );

    res_route res_route_inst (
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .csr_rd_data_i(csr_rd_data),
        .imm_i(imm), .funct3_i(funct3), .opcode_i(opcode),
        .alu_res_op_i(res_op), .alu_res_i(alu_res), .data_mem_data_i(data_mem_rdata),
        .data_mem_addr_o(mem_addr_o), .data_mem_wr_en_o(data_mem_wr_en),
        .data_mem_req_o(data_mem_req), .data_mem_data_o(mem_wdata_o),
        .reg_wr_data_o(wb_data_o), .csr_wr_data_o(csr_wr_data)
    );

    data_ram data_ram_inst (
        .clk_i, .addr_i(mem_addr_o), .req_i(data_mem_req), .wr_en_i(data_mem_wr_en),
        .wr_data_i(mem_wdata_o), .rd_data_o(data_mem_rdata)
    );

    // Store strobe as seen by the RAM
    assign mem_we_o = data_mem_req & data_mem_wr_en;

endmodule

// File: sim/tb_mem_wb.sv
module tb_mem_wb import rooth_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // Columns per vector line, see the vectors file
    localparam int          NUM_FIELDS  = 13;
    localparam int          MAX_VECTORS = 64;
    localparam int          MAX_BUBBLE  = 3;
    localparam logic [31:0] END_MARK    = 32'hff;

    logic                      clk_i;
    logic                      arst_n_i;
    logic                      valid_i;
    logic [OPCODE_WIDTH-1:0]   opcode_i;
    logic [FUNCT3_WIDTH-1:0]   funct3_i;
    logic [REG_ADDR_WIDTH-1:0] rd_i;
    logic [REG_ADDR_WIDTH-1:0] rs1_i;
    logic [REG_ADDR_WIDTH-1:0] rs2_i;
    logic [CPU_WIDTH-1:0]      imm_i;
    logic [CSR_IDX_WIDTH-1:0]  csr_idx_i;
    logic                      wb_we_o;
    logic [REG_ADDR_WIDTH-1:0] wb_rd_o;
    logic [CPU_WIDTH-1:0]      wb_data_o;
    logic                      mem_we_o;
    logic [CPU_WIDTH-1:0]      mem_addr_o;
    logic [CPU_WIDTH-1:0]      mem_wdata_o;
    logic                      csr_we_o;

    logic [31:0] vec_mem [NUM_FIELDS*MAX_VECTORS];
    logic [31:0] rnd_state    = 32'h245c;
    int          num_vec      = 0;
    int          cycles       = 0;
    int          cycle_limit  = 0;
    int          errors       = 0;
    int          checks       = 0;
    int          cur_test     = 0;
    int          test_errors  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    mem_wb_top mem_wb_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Run length guard
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rnd_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rnd_state = x;
        return x;
    endfunction

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0d ns test %0d: %s is %h, expected %h",
                     $time, cur_test, field, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            if (test_errors == 0) begin
                $display("test %0d passed", cur_test);
                tests_passed++;
            end else begin
                $display("test %0d failed with %0d errors", cur_test, test_errors);
                tests_failed++;
            end
        end
        test_errors = 0;
    endtask

    // Slot -1 is empty, -2 a bubble, otherwise a vector index
    task automatic check_slot(input int slot);
        int b;
        b = slot * NUM_FIELDS;
        if (slot == -2) begin
            check_value("wb_we in bubble", 32'(wb_we_o), 32'h0);
            check_value("mem_we in bubble", 32'(mem_we_o), 32'h0);
            check_value("csr_we in bubble", 32'(csr_we_o), 32'h0);
        end else if (slot >= 0) begin
            if (vec_mem[b+12] != cur_test) begin
                close_test();
                cur_test = vec_mem[b+12];
            end
            check_value("wb_we", 32'(wb_we_o), vec_mem[b+7]);
            if (vec_mem[b+7][0]) begin
                check_value("wb_rd", 32'(wb_rd_o), vec_mem[b+2]);
                check_value("wb_data", wb_data_o, vec_mem[b+8]);
            end
            check_value("mem_we", 32'(mem_we_o), vec_mem[b+9]);
            if (vec_mem[b+9][0]) begin
                check_value("mem_addr", mem_addr_o, vec_mem[b+10]);
                check_value("mem_wdata", mem_wdata_o, vec_mem[b+11]);
            end
            check_value("csr_we", 32'(csr_we_o),
                        32'(vec_mem[b][OPCODE_WIDTH-1:0] == INST_TYPE_CSR));
        end
    endtask

    task automatic drive_vector(input int idx);
        int b;
        b = idx * NUM_FIELDS;
        valid_i   <= 1'b1;
        opcode_i  <= vec_mem[b][OPCODE_WIDTH-1:0];
        funct3_i  <= vec_mem[b+1][FUNCT3_WIDTH-1:0];
        rd_i      <= vec_mem[b+2][REG_ADDR_WIDTH-1:0];
        rs1_i     <= vec_mem[b+3][REG_ADDR_WIDTH-1:0];
        rs2_i     <= vec_mem[b+4][REG_ADDR_WIDTH-1:0];
        imm_i     <= vec_mem[b+5];
        csr_idx_i <= vec_mem[b+6][CSR_IDX_WIDTH-1:0];
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int slot;
        int blen;
        arst_n_i  <= 1'b0;
        valid_i   <= 1'b0;
        opcode_i  <= '0;
        funct3_i  <= '0;
        rd_i      <= '0;
        rs1_i     <= '0;
        rs2_i     <= '0;
        imm_i     <= '0;
        csr_idx_i <= '0;
        $readmemh("sim/mem_wb_vectors.txt", vec_mem);
        while (num_vec < MAX_VECTORS && vec_mem[num_vec*NUM_FIELDS] != END_MARK) begin
            num_vec++;
        end
        cycle_limit = num_vec * MAX_BUBBLE + 20;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;
        slot = -1;
        for (int i = 0; i < num_vec; i++) begin
            // Bubble of random length every four vectors
            if (i > 0 && i % 4 == 0) begin
                blen = int'(next_random() % MAX_BUBBLE) + 1;
                repeat (blen) begin
                    @(posedge clk_i);
                    valid_i <= 1'b0;
                    @(negedge clk_i);
                    check_slot(slot);
                    slot = -2;
                end
            end
            @(posedge clk_i);
            drive_vector(i);
            @(negedge clk_i);
            check_slot(slot);
            slot = i;
        end
        @(posedge clk_i);
        valid_i <= 1'b0;
        @(negedge clk_i);
        check_slot(slot);
        close_test();
        if (num_vec == 0) begin
            $display("No test vectors were read");
        end
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && num_vec > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim/mem_wb_vectors.txt
// op f3 rd rs1 rs2 imm csr | wb_we wb_data mem_we mem_addr mem_wdata | test
// Register numbers in hex, opcode ff ends the list
13 0 01 00 00 00000123 0 1 00000123 0 00000000 00000000 1
13 4 02 01 00 000000f0 0 1 000001d3 0 00000000 00000000 1
13 6 03 01 00 00000700 0 1 00000723 0 00000000 00000000 1
13 7 04 03 00 000000ff 0 1 00000023 0 00000000 00000000 1
33 0 05 01 02 00000000 0 1 000002f6 0 00000000 00000000 1
33 4 06 05 03 00000000 0 1 000005d5 0 00000000 00000000 1
33 6 07 04 02 00000000 0 1 000001f3 0 00000000 00000000 1
33 7 08 06 05 00000000 0 1 000000d4 0 00000000 00000000 1
13 0 00 01 00 00000005 0 0 00000000 0 00000000 00000000 1
33 0 09 00 01 00000000 0 1 00000123 0 00000000 00000000 1
13 0 0a 00 00 00000040 0 1 00000040 0 00000000 00000000 2
13 0 0b 00 00 12345678 0 1 12345678 0 00000000 00000000 2
13 0 0c 00 00 000096e7 0 1 000096e7 0 00000000 00000000 2
23 2 00 0a 0b 00000000 0 0 00000000 1 00000040 12345678 2
23 0 00 0a 0c 00000000 0 0 00000000 1 00000040 123456e7 2
23 0 00 0a 0c 00000001 0 0 00000000 1 00000041 1234e7e7 2
23 0 00 0a 0c 00000002 0 0 00000000 1 00000042 12e7e7e7 2
23 0 00 0a 0c 00000003 0 0 00000000 1 00000043 e7e7e7e7 2
23 1 00 0a 0c 00000000 0 0 00000000 1 00000040 e7e796e7 2
23 1 00 0a 0b 00000002 0 0 00000000 1 00000042 567896e7 2
03 0 0e 0a 00 00000000 0 1 ffffffe7 0 00000000 00000000 3
03 4 0f 0a 00 00000001 0 1 00000096 0 00000000 00000000 3
03 0 10 0a 00 00000001 0 1 ffffff96 0 00000000 00000000 3
03 4 11 0a 00 00000002 0 1 00000078 0 00000000 00000000 3
03 1 12 0a 00 00000000 0 1 ffff96e7 0 00000000 00000000 3
03 5 13 0a 00 00000000 0 1 000096e7 0 00000000 00000000 3
03 1 14 0a 00 00000002 0 1 00005678 0 00000000 00000000 3
03 2 15 0a 00 00000000 0 1 567896e7 0 00000000 00000000 3
73 1 16 0b 00 00000000 1 1 00000000 0 00000000 00000000 4
73 2 17 0c 00 00000000 1 1 12345678 0 00000000 00000000 4
73 3 18 04 00 00000000 1 1 1234d6ff 0 00000000 00000000 4
73 5 19 00 00 0000001f 2 1 00000000 0 00000000 00000000 4
73 2 1a 01 00 00000000 2 1 0000001f 0 00000000 00000000 4
73 1 1b 00 00 00000000 1 1 1234d6dc 0 00000000 00000000 4
73 3 1c 0c 00 00000000 2 1 0000013f 0 00000000 00000000 4
73 2 1d 00 00 00000000 2 1 00000118 0 00000000 00000000 4
73 2 1e 00 00 00000000 1 1 00000000 0 00000000 00000000 4
13 0 01 00 00 00000010 0 1 00000010 0 00000000 00000000 5
13 0 01 01 00 00000010 0 1 00000020 0 00000000 00000000 5
33 0 02 01 01 00000000 0 1 00000040 0 00000000 00000000 5
33 4 03 02 01 00000000 0 1 00000060 0 00000000 00000000 5
23 2 00 03 02 00000000 0 0 00000000 1 00000060 00000040 5
03 2 04 03 00 00000000 0 1 00000040 0 00000000 00000000 5
13 6 05 04 00 00000001 0 1 00000041 0 00000000 00000000 5
ff

// File: list.f
verilog/rooth_pkg.sv
verilog/exec_unit.sv
verilog/reg_file.sv
verilog/csr_file.sv
verilog/res_route.sv
verilog/data_ram.sv
verilog/mem_wb_top.sv
sim/tb_mem_wb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_wb -f list.f -Mdir obj_dir

out=$(./obj_dir/Vtb_mem_wb)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi
